//--- Makefile
# Verilator build and run of the divider slice testbench
# Any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= div_slice_tb
FILELIST  ?= div_slice_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the simulator exit code
run: compile
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/div_lane.sv
/*
  One restoring divider lane. Produces one quotient bit per run cycle and
  reports divide-by-zero and a nonzero remainder as status.
*/
`timescale 1ns/1ns
`default_nettype none

module div_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  logic [LaneWidth-1:0]          dividend_i,
  input  logic [LaneWidth-1:0]          divisor_i,
  input  logic                          lane_en_i,
  lane_ctrl_if.lane                     ctrl_if,
  output logic [LaneWidth-1:0]          quotient_o,
  output div_slice_types_pkg::status_t  status_o
);

  logic                 active_q;
  logic                 dz_q;
  logic [LaneWidth-1:0] rem_q;
  logic [LaneWidth-1:0] quo_q;
  logic [LaneWidth-1:0] div_q;
  logic [LaneWidth-1:0] dividend_ld;
  logic [LaneWidth-1:0] divisor_ld;
  logic [LaneWidth:0]   partial;
  logic [LaneWidth:0]   trial;

  // INT16 in a wide lane moves the low dividend half to the top so that
  // sixteen steps leave the quotient in the low half
  assign dividend_ld = ctrl_if.wide ? dividend_i
                     : (dividend_i << (LaneWidth - div_slice_cfg_pkg::NARROW_WIDTH));
  assign divisor_ld  = ctrl_if.wide ? divisor_i
                     : (divisor_i & LaneWidth'({div_slice_cfg_pkg::NARROW_WIDTH{1'b1}}));

  // Shift in the next dividend bit and try the subtraction
  assign partial = {rem_q, quo_q[LaneWidth-1]};
  assign trial   = partial - {1'b0, div_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
    end else if (ctrl_if.start) begin
      active_q <= lane_en_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_if.start && lane_en_i) begin
      rem_q <= '0;
      quo_q <= dividend_ld;
      div_q <= divisor_ld;
      dz_q  <= (divisor_ld == '0);
    end else if (ctrl_if.run && active_q) begin
      if (!trial[LaneWidth]) begin
        // No borrow so the difference is kept
        rem_q <= trial[LaneWidth-1:0];
        quo_q <= {quo_q[LaneWidth-2:0], 1'b1};
      end else begin
        rem_q <= partial[LaneWidth-1:0];
        quo_q <= {quo_q[LaneWidth-2:0], 1'b0};
      end
    end
  end

  // A zero divisor never borrows, so the quotient ends up all ones
  assign quotient_o           = quo_q;
  assign status_o.div_by_zero = dz_q;
  assign status_o.inexact     = |rem_q;

endmodule

`default_nettype wire

//--- design/div_slice_cfg_pkg.sv
/*
  Width and step-count constants of the two-lane integer divider slice.
  Referenced by scoped name from the types package and every RTL module.
*/
`default_nettype none

package div_slice_cfg_pkg;

  // ----------------------------------------------------------
  // Data widths
  // ----------------------------------------------------------
  localparam int unsigned SLICE_WIDTH  = 32;
  localparam int unsigned NARROW_WIDTH = 16;
  localparam int unsigned NUM_LANES    = 2;
  localparam int unsigned TAG_WIDTH    = 8;

  // ----------------------------------------------------------
  // Iteration timing
  // ----------------------------------------------------------
  localparam int unsigned STEP_CNT_BITS = 6;

  // One restoring step per quotient bit
  localparam logic [STEP_CNT_BITS-1:0] STEPS_INT32 = STEP_CNT_BITS'(SLICE_WIDTH);
  localparam logic [STEP_CNT_BITS-1:0] STEPS_INT16 = STEP_CNT_BITS'(NARROW_WIDTH);

endpackage

`default_nettype wire

//--- design/div_slice_ctrl.sv
/*
  Handshake FSM of the divider slice. Accepts a request while idle, runs all
  lanes in lockstep, then holds the packed result until downstream takes it.
*/
`timescale 1ns/1ns
`default_nettype none

module div_slice_ctrl (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           in_valid_i,
  input  div_slice_types_pkg::int_fmt_e  int_fmt_i,
  input  logic                           vectorial_op_i,
  input  logic                           flush_i,
  input  logic                           out_ready_i,
  output logic                           in_ready_o,
  output logic                           out_valid_o,
  output logic                           busy_o,
  output logic                           capture_o,
  lane_ctrl_if.ctrl                      ctrl_if
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    HOLD
  } state_e;

  state_e state_q;
  logic   accept;
  logic   vec_req;
  logic   wide_q;
  logic   lane1_en_q;
  logic   capture_q;
  logic   out_valid_q;

  // ----------------------------------------------------------
  // Input side
  // ----------------------------------------------------------
  assign in_ready_o = (state_q == IDLE) & ~flush_i;
  assign accept     = in_valid_i & in_ready_o;

  // Vector flag only counts for INT16
  assign vec_req = vectorial_op_i & (int_fmt_i == div_slice_types_pkg::INT16);

  // Counter and lanes load on the accepting edge, so pass the request
  // format straight through in that cycle
  assign ctrl_if.start    = accept;
  assign ctrl_if.run      = (state_q == RUN);
  assign ctrl_if.wide     = accept ? (int_fmt_i == div_slice_types_pkg::INT32) : wide_q;
  assign ctrl_if.lane1_en = accept ? vec_req : lane1_en_q;

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      wide_q      <= 1'b1;
      lane1_en_q  <= 1'b0;
      capture_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end else if (flush_i) begin
      state_q     <= IDLE;
      capture_q   <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      capture_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q    <= RUN;
            wide_q     <= ctrl_if.wide;
            lane1_en_q <= vec_req;
          end
        end
        RUN: begin
          if (ctrl_if.last) begin
            state_q   <= HOLD;
            capture_q <= 1'b1;
          end
        end
        HOLD: begin
          // Packer registers one cycle after the final step
          if (capture_q) begin
            out_valid_q <= 1'b1;
          end
          if (out_valid_q && out_ready_i) begin
            state_q     <= IDLE;
            out_valid_q <= 1'b0;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign capture_o   = capture_q;
  assign out_valid_o = out_valid_q;
  assign busy_o      = (state_q != IDLE);

endmodule

`default_nettype wire

//--- design/div_slice_top.sv
/*
  Top level of the two-lane SIMD integer divider slice. Lane 0 divides full
  words, lane 1 the upper 16-bit halves of vectorial INT16 requests.
*/
`timescale 1ns/1ns
`default_nettype none

module div_slice_top (
  input  logic                                       clk_i,
  input  logic                                       rst_i,
  input  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  operand_a_i,
  input  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  operand_b_i,
  input  div_slice_types_pkg::int_fmt_e              int_fmt_i,
  input  logic                                       vectorial_op_i,
  input  div_slice_types_pkg::lane_mask_t            simd_mask_i,
  input  logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]    tag_i,
  input  logic                                       in_valid_i,
  output logic                                       in_ready_o,
  input  logic                                       flush_i,
  output logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  result_o,
  output div_slice_types_pkg::status_t               status_o,
  output logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]    tag_o,
  output logic                                       out_valid_o,
  input  logic                                       out_ready_i,
  output logic                                       busy_o
);

  logic                                        capture;
  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]   quotient0;
  logic [div_slice_cfg_pkg::NARROW_WIDTH-1:0]  quotient1;
  div_slice_types_pkg::status_t                status0;
  div_slice_types_pkg::status_t                status1;

  lane_ctrl_if i_lane_ctrl ();

  // ----------------------------------------------------------
  // Control
  // ----------------------------------------------------------
  div_slice_ctrl i_ctrl (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .in_valid_i     ( in_valid_i     ),
    .int_fmt_i      ( int_fmt_i      ),
    .vectorial_op_i ( vectorial_op_i ),
    .flush_i        ( flush_i        ),
    .out_ready_i    ( out_ready_i    ),
    .in_ready_o     ( in_ready_o     ),
    .out_valid_o    ( out_valid_o    ),
    .busy_o         ( busy_o         ),
    .capture_o      ( capture        ),
    .ctrl_if        ( i_lane_ctrl    )
  );

  div_step_counter i_step_counter (
    .clk_i   ( clk_i       ),
    .rst_i   ( rst_i       ),
    .ctrl_if ( i_lane_ctrl )
  );

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  div_lane #(
    .LaneWidth ( div_slice_cfg_pkg::SLICE_WIDTH )
  ) i_lane0 (
    .clk_i      ( clk_i       ),
    .rst_i      ( rst_i       ),
    .dividend_i ( operand_a_i ),
    .divisor_i  ( operand_b_i ),
    .lane_en_i  ( 1'b1        ),
    .ctrl_if    ( i_lane_ctrl ),
    .quotient_o ( quotient0   ),
    .status_o   ( status0     )
  );

  // Upper lane only starts for vectorial requests
  div_lane #(
    .LaneWidth ( div_slice_cfg_pkg::NARROW_WIDTH )
  ) i_lane1 (
    .clk_i      ( clk_i                                                   ),
    .rst_i      ( rst_i                                                   ),
    .dividend_i ( operand_a_i[div_slice_cfg_pkg::SLICE_WIDTH-1:div_slice_cfg_pkg::NARROW_WIDTH] ),
    .divisor_i  ( operand_b_i[div_slice_cfg_pkg::SLICE_WIDTH-1:div_slice_cfg_pkg::NARROW_WIDTH] ),
    .lane_en_i  ( i_lane_ctrl.lane1_en                                    ),
    .ctrl_if    ( i_lane_ctrl                                             ),
    .quotient_o ( quotient1                                               ),
    .status_o   ( status1                                                 )
  );

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  result_packer i_packer (
    .clk_i       ( clk_i                ),
    .rst_i       ( rst_i                ),
    .start_i     ( i_lane_ctrl.start    ),
    .capture_i   ( capture              ),
    .wide_i      ( i_lane_ctrl.wide     ),
    .lane1_en_i  ( i_lane_ctrl.lane1_en ),
    .mask_i      ( simd_mask_i          ),
    .tag_i       ( tag_i                ),
    .quotient0_i ( quotient0            ),
    .quotient1_i ( quotient1            ),
    .status0_i   ( status0              ),
    .status1_i   ( status1              ),
    .result_o    ( result_o             ),
    .status_o    ( status_o             ),
    .tag_o       ( tag_o                )
  );

endmodule

`default_nettype wire

//--- design/div_slice_types_pkg.sv
/*
  Types shared by the divider slice: integer format, status flags, SIMD mask
  and the result word that is read whole or as two 16-bit halves.
*/
`default_nettype none

package div_slice_types_pkg;

  // ----------------------------------------------------------
  // Request descriptors
  // ----------------------------------------------------------
  typedef enum logic {
    INT16 = 1'b0,
    INT32 = 1'b1
  } int_fmt_e;

  // One enable bit per lane with lane 0 in bit 0
  typedef logic [div_slice_cfg_pkg::NUM_LANES-1:0] lane_mask_t;

  // ----------------------------------------------------------
  // Result side
  // ----------------------------------------------------------
  typedef struct packed {
    logic div_by_zero;
    logic inexact;
  } status_t;

  // Scalar INT32 uses word, INT16 results use halves
  // Lane 0 owns halves[0], the low half of the word
  typedef union packed {
    logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0] word;
    logic [div_slice_cfg_pkg::NUM_LANES-1:0][div_slice_cfg_pkg::NARROW_WIDTH-1:0] halves;
  } slice_word_u;

endpackage

`default_nettype wire

//--- design/div_step_counter.sv
/*
  Step counter shared by all lanes. Loaded with the quotient width at start
  and decremented once per run cycle; flags the cycle of the final step.
*/
`timescale 1ns/1ns
`default_nettype none

module div_step_counter (
  input  logic         clk_i,
  input  logic         rst_i,
  lane_ctrl_if.counter ctrl_if
);

  logic [div_slice_cfg_pkg::STEP_CNT_BITS-1:0] cnt_q;
  logic [div_slice_cfg_pkg::STEP_CNT_BITS-1:0] cnt_dec;

  assign cnt_dec = cnt_q - 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (ctrl_if.start) begin
      cnt_q <= ctrl_if.wide ? div_slice_cfg_pkg::STEPS_INT32
                            : div_slice_cfg_pkg::STEPS_INT16;
    end else if (ctrl_if.run && (cnt_q != '0)) begin
      cnt_q <= cnt_dec;
    end
  end

  // One step left when the count is 1
  assign ctrl_if.last = ctrl_if.run && (cnt_dec == '0);

endmodule

`default_nettype wire

//--- design/lane_ctrl_if.sv
/*
  Lockstep control bundle from the slice controller to the step counter and
  the divider lanes. The counter returns the last-step flag.
*/
`timescale 1ns/1ns
`default_nettype none

interface lane_ctrl_if;

  logic start;     // Request accepted this cycle
  logic run;       // Division steps in progress
  logic wide;      // INT32 request
  logic lane1_en;  // Vectorial INT16 request, upper lane active
  logic last;      // Final step in this cycle

  modport ctrl    (output start, output run, output wide, output lane1_en, input last);
  modport counter (input start, input run, input wide, output last);
  modport lane    (input start, input run, input wide);

endinterface

`default_nettype wire

//--- design/result_packer.sv
/*
  Output register bank of the slice. Keeps tag and SIMD mask from acceptance,
  then packs the lane quotients and the masked status on capture.
*/
`timescale 1ns/1ns
`default_nettype none

module result_packer (
  input  logic                                         clk_i,
  input  logic                                         rst_i,
  input  logic                                         start_i,
  input  logic                                         capture_i,
  input  logic                                         wide_i,
  input  logic                                         lane1_en_i,
  input  div_slice_types_pkg::lane_mask_t              mask_i,
  input  logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]      tag_i,
  input  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]    quotient0_i,
  input  logic [div_slice_cfg_pkg::NARROW_WIDTH-1:0]   quotient1_i,
  input  div_slice_types_pkg::status_t                 status0_i,
  input  div_slice_types_pkg::status_t                 status1_i,
  output logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]    result_o,
  output div_slice_types_pkg::status_t                 status_o,
  output logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]      tag_o
);

  div_slice_types_pkg::slice_word_u          packed_d;
  div_slice_types_pkg::slice_word_u          result_q;
  div_slice_types_pkg::status_t              status_d;
  div_slice_types_pkg::status_t              status_q;
  div_slice_types_pkg::lane_mask_t           mask_q;
  logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]   tag_q;

  // ----------------------------------------------------------
  // Packing by format with the unused upper half zero-extended
  // ----------------------------------------------------------
  always_comb begin : pack_result
    packed_d = '0;
    if (wide_i) begin
      packed_d.word = quotient0_i;
    end else begin
      packed_d.halves[0] = quotient0_i[div_slice_cfg_pkg::NARROW_WIDTH-1:0];
      if (lane1_en_i) begin
        packed_d.halves[1] = quotient1_i;
      end
    end
  end

  // Lane 1 only counts for vector requests
  always_comb begin : collapse_status
    status_d = status0_i & {$bits(div_slice_types_pkg::status_t){mask_q[0]}};
    if (lane1_en_i) begin
      status_d = status_d | (status1_i & {$bits(div_slice_types_pkg::status_t){mask_q[1]}});
    end
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mask_q   <= '0;
      status_q <= '0;
    end else begin
      if (start_i) begin
        mask_q <= mask_i;
      end
      if (capture_i) begin
        status_q <= status_d;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      tag_q <= tag_i;
    end
    if (capture_i) begin
      result_q <= packed_d;
    end
  end

  assign result_o = result_q.word;
  assign status_o = status_q;
  assign tag_o    = tag_q;

endmodule

`default_nettype wire

//--- div_slice_top.f
design/div_slice_cfg_pkg.sv
design/div_slice_types_pkg.sv
design/lane_ctrl_if.sv
design/div_slice_ctrl.sv
design/div_step_counter.sv
design/div_lane.sv
design/result_packer.sv
design/div_slice_top.sv
verif/div_slice_tb.sv

//--- verif/div_slice_tb.sv
/*
  Directed testbench of the two-lane divider slice. Runs scalar, vectorial,
  back-pressure and flush requests and checks them against a reference model.
*/
`timescale 1ns/1ns
`default_nettype none

module div_slice_tb;

  localparam int MAX_WAIT = 100;

  logic                                       clk_i;
  logic                                       rst_i;
  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  operand_a_i;
  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  operand_b_i;
  div_slice_types_pkg::int_fmt_e              int_fmt_i;
  logic                                       vectorial_op_i;
  div_slice_types_pkg::lane_mask_t            simd_mask_i;
  logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]    tag_i;
  logic                                       in_valid_i;
  logic                                       in_ready_o;
  logic                                       flush_i;
  logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0]  result_o;
  div_slice_types_pkg::status_t               status_o;
  logic [div_slice_cfg_pkg::TAG_WIDTH-1:0]    tag_o;
  logic                                       out_valid_o;
  logic                                       out_ready_i;
  logic                                       busy_o;

  int error_count   = 0;
  int timeout_count = 0;
  int cycle_cnt     = 0;
  int seed          = 91;

  div_slice_top UUT (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .operand_a_i    ( operand_a_i    ),
    .operand_b_i    ( operand_b_i    ),
    .int_fmt_i      ( int_fmt_i      ),
    .vectorial_op_i ( vectorial_op_i ),
    .simd_mask_i    ( simd_mask_i    ),
    .tag_i          ( tag_i          ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Counts rising edges and is read only at falling edges
  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] ref_quotient32(input logic [31:0] a, input logic [31:0] b);
    return (b == '0) ? 32'hFFFF_FFFF : a / b;
  endfunction

  function automatic logic [15:0] ref_quotient16(input logic [15:0] a, input logic [15:0] b);
    return (b == '0) ? 16'hFFFF : a / b;
  endfunction

  // Division by zero leaves the dividend as remainder
  function automatic div_slice_types_pkg::status_t ref_status(input logic [31:0] a,
                                                              input logic [31:0] b);
    div_slice_types_pkg::status_t st;
    st.div_by_zero = (b == '0);
    st.inexact     = (b == '0) ? (a != '0) : ((a % b) != '0);
    return st;
  endfunction

  function automatic div_slice_types_pkg::status_t merge_status(
    input div_slice_types_pkg::status_t st0, input logic en0,
    input div_slice_types_pkg::status_t st1, input logic en1);
    div_slice_types_pkg::status_t st;
    st.div_by_zero = (st0.div_by_zero & en0) | (st1.div_by_zero & en1);
    st.inexact     = (st0.inexact & en0) | (st1.inexact & en1);
    return st;
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_word(input string name,
                            input logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0] exp,
                            input logic [div_slice_cfg_pkg::SLICE_WIDTH-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_status(input string name, input div_slice_types_pkg::status_t exp,
                              input div_slice_types_pkg::status_t act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s status: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_tag(input string name,
                           input logic [div_slice_cfg_pkg::TAG_WIDTH-1:0] exp,
                           input logic [div_slice_cfg_pkg::TAG_WIDTH-1:0] act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s tag: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_latency(input string name, input int exp, input int act);
    if (act != exp) begin
      error_count++;
      $display("CHECK FAILED %s latency: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // ----------------------------------------------------------
  // Handshake helpers
  // ----------------------------------------------------------
  task automatic send_request(input logic [31:0] a, input logic [31:0] b,
                              input div_slice_types_pkg::int_fmt_e fmt, input logic vec,
                              input div_slice_types_pkg::lane_mask_t mask,
                              input logic [7:0] tag, output bit ok, output int accept_cycle);
    int waited;
    waited = 0;
    ok = 1'b0;
    accept_cycle = 0;
    @(posedge clk_i);
    #2;
    operand_a_i    = a;
    operand_b_i    = b;
    int_fmt_i      = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = tag;
    in_valid_i     = 1'b1;
    while (!ok && waited < MAX_WAIT) begin
      @(negedge clk_i);
      if (in_ready_o) begin
        ok = 1'b1;
        accept_cycle = cycle_cnt + 1;
      end
      @(posedge clk_i);
      waited++;
    end
    #2;
    in_valid_i = 1'b0;
    if (!ok) begin
      timeout_count++;
      $display("Timeout: the slice never accepted a request");
    end
  endtask

  task automatic wait_valid(output bit ok, output int valid_cycle);
    int waited;
    waited = 0;
    ok = 1'b0;
    valid_cycle = 0;
    while (!ok && waited < MAX_WAIT) begin
      @(negedge clk_i);
      if (out_valid_o) begin
        ok = 1'b1;
        valid_cycle = cycle_cnt;
      end
      waited++;
    end
    if (!ok) begin
      timeout_count++;
      $display("Timeout: no result came back from the slice");
    end
  endtask

  task automatic run_division(input string name, input logic [31:0] a, input logic [31:0] b,
                              input div_slice_types_pkg::int_fmt_e fmt, input logic vec,
                              input div_slice_types_pkg::lane_mask_t mask,
                              input logic [31:0] exp_word,
                              input div_slice_types_pkg::status_t exp_status,
                              input int exp_latency);
    bit         ok;
    int         acc;
    int         vc;
    logic [7:0] tag;
    tag = 8'($random(seed));
    send_request(a, b, fmt, vec, mask, tag, ok, acc);
    if (!ok) return;
    wait_valid(ok, vc);
    if (!ok) return;
    check_latency(name, exp_latency, vc - acc);
    check_word(name, exp_word, result_o);
    check_status(name, exp_status, status_o);
    check_tag(name, tag, tag_o);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    @(negedge clk_i);
    check_flag("reset in_ready", 1'b1, in_ready_o);
    check_flag("reset out_valid", 1'b0, out_valid_o);
    check_flag("reset busy", 1'b0, busy_o);
  endtask

  task automatic test_scalar_int32();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 3; i++) begin
      a = $random(seed);
      b = 32'($random(seed)) >> ($random(seed) & 31);
      if (b == '0) b = 32'd1;
      run_division($sformatf("int32_%0d", i), a, b, div_slice_types_pkg::INT32, 1'b1,
                   2'b11, ref_quotient32(a, b),
                   merge_status(ref_status(a, b), 1'b1, '0, 1'b0), 33);
    end
  endtask

  task automatic test_scalar_int16();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 2; i++) begin
      a = $random(seed);
      b = $random(seed);
      b[15:0] = b[15:0] >> ($random(seed) & 15);
      if (b[15:0] == '0) b[15:0] = 16'd3;
      run_division($sformatf("int16_%0d", i), a, b, div_slice_types_pkg::INT16, 1'b0,
                   2'b11, {16'h0000, ref_quotient16(a[15:0], b[15:0])},
                   merge_status(ref_status({16'h0, a[15:0]}, {16'h0, b[15:0]}), 1'b1,
                                '0, 1'b0), 17);
    end
  endtask

  task automatic vector_case(input string name, input logic [31:0] a, input logic [31:0] b,
                             input div_slice_types_pkg::lane_mask_t mask);
    div_slice_types_pkg::status_t st_lo;
    div_slice_types_pkg::status_t st_hi;
    st_lo = ref_status({16'h0, a[15:0]}, {16'h0, b[15:0]});
    st_hi = ref_status({16'h0, a[31:16]}, {16'h0, b[31:16]});
    run_division(name, a, b, div_slice_types_pkg::INT16, 1'b1, mask,
                 {ref_quotient16(a[31:16], b[31:16]), ref_quotient16(a[15:0], b[15:0])},
                 merge_status(st_lo, mask[0], st_hi, mask[1]), 17);
  endtask

  task automatic test_vector_int16();
    logic [31:0] a;
    logic [31:0] b;
    a = $random(seed);
    b = {16'($random(seed)) >> 7, 16'($random(seed)) >> 9};
    if (b[15:0] == '0) b[15:0] = 16'd5;
    if (b[31:16] == '0) b[31:16] = 16'd7;
    vector_case("vec_both", a, b, 2'b11);
    // Upper divisor zero seen with and without mask bit 1
    b[31:16] = 16'h0000;
    vector_case("vec_dz_masked_in", a, b, 2'b11);
    vector_case("vec_dz_masked_out", a, b, 2'b01);
  endtask

  task automatic test_back_pressure();
    bit                           ok;
    int                           acc;
    int                           vc;
    logic [31:0]                  a;
    logic [31:0]                  b;
    div_slice_types_pkg::status_t exp_st;
    a = $random(seed);
    b = 32'($random(seed)) >> 20;
    if (b == '0) b = 32'd9;
    exp_st = merge_status(ref_status(a, b), 1'b1, '0, 1'b0);
    @(posedge clk_i);
    #2;
    out_ready_i = 1'b0;
    send_request(a, b, div_slice_types_pkg::INT32, 1'b0, 2'b01, 8'h5A, ok, acc);
    if (!ok) return;
    wait_valid(ok, vc);
    if (!ok) return;
    check_latency("stall", 33, vc - acc);
    repeat (5) begin
      @(negedge clk_i);
      check_word("stall result", ref_quotient32(a, b), result_o);
      check_status("stall", exp_st, status_o);
      check_tag("stall", 8'h5A, tag_o);
      check_flag("stall out_valid", 1'b1, out_valid_o);
      check_flag("stall in_ready", 1'b0, in_ready_o);
      check_flag("stall busy", 1'b1, busy_o);
    end
    @(posedge clk_i);
    #2;
    out_ready_i = 1'b1;
    @(negedge clk_i);
    check_flag("take in_ready before edge", 1'b0, in_ready_o);
    @(negedge clk_i);
    check_flag("taken out_valid", 1'b0, out_valid_o);
    check_flag("taken in_ready", 1'b1, in_ready_o);
    check_flag("taken busy", 1'b0, busy_o);
  endtask

  task automatic test_flush();
    bit          ok;
    bit          seen;
    int          acc;
    logic [31:0] a;
    logic [31:0] b;
    seen = 1'b0;
    send_request(32'h1234_5678, 32'h0000_0013, div_slice_types_pkg::INT32, 1'b0, 2'b01,
                 8'hC3, ok, acc);
    if (!ok) return;
    repeat (10) @(posedge clk_i);
    #2;
    flush_i = 1'b1;
    @(posedge clk_i);
    #2;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_flag("flush in_ready", 1'b1, in_ready_o);
    check_flag("flush busy", 1'b0, busy_o);
    // The aborted request must never show up
    repeat (40) begin
      @(negedge clk_i);
      if (out_valid_o) seen = 1'b1;
    end
    check_flag("flush no result", 1'b0, seen);
    a = $random(seed);
    b = 32'($random(seed)) >> 12;
    if (b == '0) b = 32'd11;
    run_division("after_flush", a, b, div_slice_types_pkg::INT32, 1'b0, 2'b01,
                 ref_quotient32(a, b), merge_status(ref_status(a, b), 1'b1, '0, 1'b0), 33);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    rst_i          = 1'b1;
    operand_a_i    = '0;
    operand_b_i    = '0;
    int_fmt_i      = div_slice_types_pkg::INT32;
    vectorial_op_i = 1'b0;
    simd_mask_i    = 2'b11;
    tag_i          = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (4) @(posedge clk_i);
    #2;
    rst_i = 1'b0;

    test_reset_state();
    if (timeout_count == 0) test_scalar_int32();
    if (timeout_count == 0) test_scalar_int16();
    if (timeout_count == 0) test_vector_int16();
    if (timeout_count == 0) test_back_pressure();
    if (timeout_count == 0) test_flush();

    $display("Errors: %0d failed checks, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
